/* rtl/rv_defs.svh */
// *****************************
// core-wide sizes, reset vector and instruction field positions
// include before any use of rv_pkg or the core modules
// *****************************
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN        64
`define RV_REG_COUNT   32
// 32-bit instruction words
`define RV_IMEM_WORDS  256
// 64-bit data doublewords
`define RV_DMEM_WORDS  128
// byte address of the first instruction
`define RV_PC_RESET    64'h0

// instruction field positions
`define RV_F_OPCODE    6:0
`define RV_F_RD        11:7
`define RV_F_FUNCT3    14:12
`define RV_F_RS1       19:15
`define RV_F_RS2       24:20
`define RV_F_FUNCT7    31:25
`define RV_F_SIGN      31
`define RV_INST_EBREAK 32'h0010_0073

`endif

/* rtl/rv_pkg.sv */
// *****************************
// shared types of the rv64 core, referenced as rv_pkg::name
// *****************************
`default_nettype none
`include "rv_defs.svh"

package rv_pkg;

  // data word and instruction
  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [31:0]         inst_t;
  // register index
  typedef logic [4:0]          reg_id_t;
  // instruction memory word index
  typedef logic [7:0]          imem_addr_t;

  // major opcodes in use
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  // halt and trap are sticky until reset
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_halt,
    st_trap
  } core_state_t;

endpackage

`default_nettype wire

/* rtl/rv_decoder.sv */
// *****************************
// combinational instruction decoder
// feeds register ids, immediate and control flags to the datapath
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_decoder (
  input  rv_pkg::inst_t   inst,
  output rv_pkg::reg_id_t rd,
  output rv_pkg::reg_id_t rs1,
  output rv_pkg::reg_id_t rs2,
  output rv_pkg::xlen_t   imm,
  output rv_pkg::alu_op_t alu_op,
  output logic            need_imm,
  output logic            use_pc,
  output logic            zero_op1,
  output logic            is_jal,
  output logic            is_load,
  output logic            reg_wen,
  output logic            mem_wen,
  output logic            is_ebreak,
  output logic            inst_illegal
);

  rv_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            sign;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_s;
  rv_pkg::xlen_t   imm_u;
  rv_pkg::xlen_t   imm_j;

  assign opcode = rv_pkg::opcode_t'(inst[`RV_F_OPCODE]);
  assign funct3 = inst[`RV_F_FUNCT3];
  assign funct7 = inst[`RV_F_FUNCT7];
  assign sign   = inst[`RV_F_SIGN];

  // register fields sit at fixed positions in every format
  assign rd  = inst[`RV_F_RD];
  assign rs1 = inst[`RV_F_RS1];
  assign rs2 = inst[`RV_F_RS2];

  // sign-extended immediates per format
  assign imm_i = {{(`RV_XLEN-12){sign}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){sign}}, inst[31:25], inst[11:7]};
  assign imm_u = {{(`RV_XLEN-32){sign}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm          = imm_i;
    alu_op       = rv_pkg::alu_add;
    need_imm     = 1'b0;
    use_pc       = 1'b0;
    zero_op1     = 1'b0;
    is_jal       = 1'b0;
    is_load      = 1'b0;
    reg_wen      = 1'b0;
    mem_wen      = 1'b0;
    is_ebreak    = 1'b0;
    inst_illegal = 1'b0;
    case (opcode)
      rv_pkg::opc_op: begin
        reg_wen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = rv_pkg::alu_add;
          10'b0100000_000: alu_op = rv_pkg::alu_sub;
          10'b0000000_111: alu_op = rv_pkg::alu_and;
          10'b0000000_110: alu_op = rv_pkg::alu_or;
          10'b0000000_100: alu_op = rv_pkg::alu_xor;
          10'b0000000_010: alu_op = rv_pkg::alu_slt;
          default:         inst_illegal = 1'b1;
        endcase
      end
      rv_pkg::opc_op_imm: begin
        reg_wen  = 1'b1;
        need_imm = 1'b1;
        // shifts and sltiu are not supported
        case (funct3)
          3'b000:  alu_op = rv_pkg::alu_add;
          3'b111:  alu_op = rv_pkg::alu_and;
          3'b110:  alu_op = rv_pkg::alu_or;
          3'b100:  alu_op = rv_pkg::alu_xor;
          3'b010:  alu_op = rv_pkg::alu_slt;
          default: inst_illegal = 1'b1;
        endcase
      end
      rv_pkg::opc_lui: begin
        // 0 + imm_u
        imm      = imm_u;
        need_imm = 1'b1;
        zero_op1 = 1'b1;
        reg_wen  = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        imm      = imm_u;
        need_imm = 1'b1;
        use_pc   = 1'b1;
        reg_wen  = 1'b1;
      end
      rv_pkg::opc_jal: begin
        // link value comes from the writeback mux
        imm     = imm_j;
        is_jal  = 1'b1;
        reg_wen = 1'b1;
      end
      rv_pkg::opc_load: begin
        need_imm     = 1'b1;
        is_load      = 1'b1;
        reg_wen      = 1'b1;
        // ld only
        inst_illegal = (funct3 != 3'b011);
      end
      rv_pkg::opc_store: begin
        imm          = imm_s;
        need_imm     = 1'b1;
        mem_wen      = 1'b1;
        // sd only
        inst_illegal = (funct3 != 3'b011);
      end
      rv_pkg::opc_system: begin
        is_ebreak    = (inst == `RV_INST_EBREAK);
        inst_illegal = (inst != `RV_INST_EBREAK);
      end
      default: inst_illegal = 1'b1;
    endcase
    // nothing commits from an undefined encoding
    if (inst_illegal) begin
      reg_wen = 1'b0;
      mem_wen = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
// *****************************
// integer register file, two operand reads, one debug read
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_regfile (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::reg_id_t rs1,
  input  rv_pkg::reg_id_t rs2,
  input  rv_pkg::reg_id_t dbg_addr,
  input  rv_pkg::reg_id_t rd,
  input  rv_pkg::xlen_t   wdata,
  input  logic            wen,
  output rv_pkg::xlen_t   rdata_1,
  output rv_pkg::xlen_t   rdata_2,
  output rv_pkg::xlen_t   dbg_data
);

  rv_pkg::xlen_t regs [`RV_REG_COUNT];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      // x0 never takes a write
      regs[rd] <= wdata;
    end
  end

  // x0 hardwired to zero on every read port
  assign rdata_1  = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2  = (rs2 == '0) ? '0 : regs[rs2];
  assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
// *****************************
// combinational alu for the integer core
// *****************************
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  rv_pkg::xlen_t   operand_1,
  input  rv_pkg::xlen_t   operand_2,
  input  rv_pkg::alu_op_t alu_op,
  output rv_pkg::xlen_t   result
);

  logic less;

  // signed compare for slt and slti
  assign less = $signed(operand_1) < $signed(operand_2);

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add: result = operand_1 + operand_2;
      rv_pkg::alu_sub: result = operand_1 - operand_2;
      rv_pkg::alu_and: result = operand_1 & operand_2;
      rv_pkg::alu_or:  result = operand_1 | operand_2;
      rv_pkg::alu_xor: result = operand_1 ^ operand_2;
      rv_pkg::alu_slt: begin
        result    = '0;
        result[0] = less;
      end
      default:         result = operand_1 + operand_2;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_memory.sv */
// *****************************
// instruction memory with program load port, plus data memory
// both read combinationally, write on the rising edge
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_memory (
  input  logic               clk,
  input  logic               load_en,
  input  rv_pkg::imem_addr_t load_addr,
  input  rv_pkg::inst_t      load_data,
  input  rv_pkg::xlen_t      pc,
  input  rv_pkg::xlen_t      daddr,
  input  rv_pkg::xlen_t      wdata,
  input  logic               wen,
  output rv_pkg::inst_t      inst,
  output rv_pkg::xlen_t      rdata
);

  localparam int imem_aw = $clog2(`RV_IMEM_WORDS);
  localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

  rv_pkg::inst_t imem [`RV_IMEM_WORDS];
  rv_pkg::xlen_t dmem [`RV_DMEM_WORDS];

  logic [imem_aw-1:0] imem_idx;
  logic [dmem_aw-1:0] dmem_idx;

  // byte pc to word index, upper bits dropped so it wraps
  assign imem_idx = pc[imem_aw+1:2];
  // daddr already counts doublewords
  assign dmem_idx = daddr[dmem_aw-1:0];

  // program load
  always_ff @(posedge clk) begin
    if (load_en) begin
      imem[load_addr] <= load_data;
    end
  end

  assign inst = imem[imem_idx];

  // sd path, full doubleword only
  always_ff @(posedge clk) begin
    if (wen) begin
      dmem[dmem_idx] <= wdata;
    end
  end

  // ld path
  assign rdata = dmem[dmem_idx];

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
// *****************************
// pc register and run/halt/trap control of the core
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_fetch (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          start,
  input  logic          is_jal,
  input  logic          is_ebreak,
  input  logic          inst_illegal,
  input  rv_pkg::xlen_t imm,
  output rv_pkg::xlen_t pc,
  output logic          running,
  output logic          halted,
  output logic          illegal
);

  rv_pkg::core_state_t state;
  rv_pkg::core_state_t state_nxt;
  rv_pkg::xlen_t       pc_nxt;

  always_comb begin
    state_nxt = state;
    pc_nxt    = pc;
    case (state)
      rv_pkg::st_idle: begin
        if (start) begin
          state_nxt = rv_pkg::st_run;
        end
      end
      rv_pkg::st_run: begin
        // pc stays on the offending instruction
        if (inst_illegal) begin
          state_nxt = rv_pkg::st_trap;
        end else if (is_ebreak) begin
          state_nxt = rv_pkg::st_halt;
        end else begin
          pc_nxt = is_jal ? (pc + imm) : (pc + 64'd4);
        end
      end
      // halt and trap hold until reset
      default: state_nxt = state;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rv_pkg::st_idle;
      pc    <= `RV_PC_RESET;
    end else begin
      state <= state_nxt;
      pc    <= pc_nxt;
    end
  end

  assign running = (state == rv_pkg::st_run);
  assign halted  = (state == rv_pkg::st_halt);
  assign illegal = (state == rv_pkg::st_trap);

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
// *****************************
// single-cycle rv64 core top, one instruction per clock in run
// load the program while idle, then pulse start
// *****************************
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  logic               load_en,
  input  rv_pkg::imem_addr_t load_addr,
  input  rv_pkg::inst_t      load_data,
  input  rv_pkg::reg_id_t    dbg_addr,
  output rv_pkg::xlen_t      pc,
  output logic               halted,
  output logic               illegal,
  output rv_pkg::reg_id_t    dbg_data_unused_never,
  output rv_pkg::xlen_t      dbg_data
);

  rv_pkg::inst_t   inst;
  rv_pkg::reg_id_t rd;
  rv_pkg::reg_id_t rs1;
  rv_pkg::reg_id_t rs2;
  rv_pkg::xlen_t   imm;
  rv_pkg::alu_op_t alu_op;
  logic            need_imm;
  logic            use_pc;
  logic            zero_op1;
  logic            is_jal;
  logic            is_load;
  logic            reg_wen;
  logic            mem_wen;
  logic            is_ebreak;
  logic            inst_illegal;
  logic            running;
  logic            imem_load;
  rv_pkg::xlen_t   rdata_1;
  rv_pkg::xlen_t   rdata_2;
  rv_pkg::xlen_t   operand_1;
  rv_pkg::xlen_t   operand_2;
  rv_pkg::xlen_t   alu_result;
  rv_pkg::xlen_t   mem_rdata;
  rv_pkg::xlen_t   daddr;
  rv_pkg::xlen_t   wb_data;

  // echo of the debug index for the testbench
  assign dbg_data_unused_never = dbg_addr;

  // program load only while idle
  assign imem_load = load_en & ~running & ~halted & ~illegal;

  rv_fetch fetch_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .is_jal       (is_jal),
    .is_ebreak    (is_ebreak),
    .inst_illegal (inst_illegal),
    .imm          (imm),
    .pc           (pc),
    .running      (running),
    .halted       (halted),
    .illegal      (illegal)
  );

  rv_memory memory_i (
    .clk       (clk),
    .load_en   (imem_load),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .daddr     (daddr),
    .wdata     (rdata_2),
    .wen       (mem_wen & running),
    .inst      (inst),
    .rdata     (mem_rdata)
  );

  rv_decoder decoder_i (
    .inst         (inst),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .alu_op       (alu_op),
    .need_imm     (need_imm),
    .use_pc       (use_pc),
    .zero_op1     (zero_op1),
    .is_jal       (is_jal),
    .is_load      (is_load),
    .reg_wen      (reg_wen),
    .mem_wen      (mem_wen),
    .is_ebreak    (is_ebreak),
    .inst_illegal (inst_illegal)
  );

  // writes only commit in run
  rv_regfile regfile_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .dbg_addr (dbg_addr),
    .rd       (rd),
    .wdata    (wb_data),
    .wen      (reg_wen & running),
    .rdata_1  (rdata_1),
    .rdata_2  (rdata_2),
    .dbg_data (dbg_data)
  );

  // operand muxes, pc for auipc, zero for lui
  assign operand_1 = use_pc ? pc : (zero_op1 ? '0 : rdata_1);
  assign operand_2 = need_imm ? imm : rdata_2;

  rv_alu alu_i (
    .operand_1 (operand_1),
    .operand_2 (operand_2),
    .alu_op    (alu_op),
    .result    (alu_result)
  );

  // doubleword index into data memory
  assign daddr = alu_result >> 3;

  // link, load data or alu result
  assign wb_data = is_jal ? (pc + 64'd4) : (is_load ? mem_rdata : alu_result);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// *****************************
// testbench clock and power-on reset
// 100 ns clock, reset low for 8 cycles
// *****************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // half period 50 ns
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // released on a falling edge, away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/rv_core_checker.sv */
// *****************************
// assertions on the rv64 core, bound into rv_core_top
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_checker (
  input logic            clk,
  input logic            arst_n,
  input rv_pkg::xlen_t   pc,
  input logic            halted,
  input logic            illegal,
  input rv_pkg::reg_id_t rs1,
  input rv_pkg::xlen_t   rdata_1,
  input rv_pkg::reg_id_t dbg_addr,
  input rv_pkg::xlen_t   dbg_data
);

  // read back by the testbench at the end of the run
  int assert_fails = 0;

  // x0 hardwired, operand and debug ports
  x0_operand_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (rs1 == '0) |-> (rdata_1 == '0))
    else begin
      assert_fails++;
      $error("x0 read nonzero on operand port 1");
    end

  x0_debug_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (dbg_addr == '0) |-> (dbg_data == '0))
    else begin
      assert_fails++;
      $error("x0 read nonzero on the debug port");
    end

  // halt and trap are exclusive states
  status_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(halted && illegal))
    else begin
      assert_fails++;
      $error("halted and illegal high together");
    end

  // pc frozen once stopped
  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    (halted || illegal) |=> $stable(pc))
    else begin
      assert_fails++;
      $error("pc moved while the core was stopped");
    end

  pc_in_reset: assert property (@(posedge clk)
    !arst_n |-> (pc == `RV_PC_RESET))
    else begin
      assert_fails++;
      $error("pc differs from the reset vector during reset");
    end

endmodule

bind rv_core_top rv_core_checker checker_i (
  .clk      (clk),
  .arst_n   (arst_n),
  .pc       (pc),
  .halted   (halted),
  .illegal  (illegal),
  .rs1      (rs1),
  .rdata_1  (rdata_1),
  .dbg_addr (dbg_addr),
  .dbg_data (dbg_data)
);

`default_nettype wire

/* verification/rv_core_tb.sv */
// *****************************
// rv64 core testbench, runs each program of the golden file
// then checks status, pc and registers over the debug port
// *****************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_tb;

  logic               clk;
  logic               por_n;
  logic               tb_rst_n;
  logic               arst_n;
  logic               start;
  logic               load_en;
  rv_pkg::imem_addr_t load_addr;
  rv_pkg::inst_t      load_data;
  rv_pkg::reg_id_t    dbg_addr;
  rv_pkg::reg_id_t    dbg_echo;
  rv_pkg::xlen_t      dbg_data;
  rv_pkg::xlen_t      pc;
  logic               halted;
  logic               illegal;

  int checks;
  int errors;
  int timeouts;
  int file_errors;
  int cycles_por;

  // program being collected from the golden file
  rv_pkg::inst_t prog_words [$];
  int            exp_idx [$];
  rv_pkg::xlen_t exp_val [$];
  logic [63:0]   exp_halted;
  logic [63:0]   exp_illegal;
  rv_pkg::xlen_t exp_pc;

  // power-on reset or a per-program reset
  assign arst_n = por_n & tb_rst_n;

  tb_clock_gen clock_gen_i (
    .clk    (clk),
    .arst_n (por_n)
  );

  rv_core_top dut_i (
    .clk                   (clk),
    .arst_n                (arst_n),
    .start                 (start),
    .load_en               (load_en),
    .load_addr             (load_addr),
    .load_data             (load_data),
    .dbg_addr              (dbg_addr),
    .pc                    (pc),
    .halted                (halted),
    .illegal               (illegal),
    .dbg_data_unused_never (dbg_echo),
    .dbg_data              (dbg_data)
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // 8 cycles of reset, all drives on the falling edge
  task automatic apply_reset();
    @(negedge clk);
    tb_rst_n = 1'b0;
    start    = 1'b0;
    load_en  = 1'b0;
    repeat (8) @(negedge clk);
    tb_rst_n = 1'b1;
    @(negedge clk);
  endtask

  // one word per cycle through the load port
  task automatic load_program();
    foreach (prog_words[i]) begin
      load_en   = 1'b1;
      load_addr = rv_pkg::imem_addr_t'(i);
      load_data = prog_words[i];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  task automatic run_program(input int num);
    int cycles;
    apply_reset();
    // idle, nothing left over from the previous run
    check_value("halted", 64'(halted), 64'd0);
    check_value("illegal", 64'(illegal), 64'd0);
    check_value("pc", pc, `RV_PC_RESET);
    load_program();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 0;
    while (!halted && !illegal && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted && !illegal) begin
      timeouts++;
      $display("program %0d neither halted nor trapped within 200 cycles", num);
    end
    check_value("halted", 64'(halted), exp_halted);
    check_value("illegal", 64'(illegal), exp_illegal);
    check_value("pc", pc, exp_pc);
    // core is stopped, register contents hold still
    foreach (exp_idx[k]) begin
      dbg_addr = rv_pkg::reg_id_t'(exp_idx[k]);
      @(negedge clk);
      check_value($sformatf("x%0d", exp_idx[k]), dbg_data, exp_val[k]);
      check_value("dbg_data_unused_never", 64'(dbg_echo), 64'(exp_idx[k]));
    end
  endtask

  task automatic run_golden();
    int          fd;
    int          n;
    int          idx;
    int          prog;
    logic        ok;
    byte         tag;
    string       text;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    prog = 0;
    fd   = $fopen("verification/rv_core_golden.txt", "r");
    if (fd == 0) begin
      file_errors++;
      $display("could not open the golden file");
      return;
    end
    while ($fgets(text, fd) != 0) begin
      tag = (text.len() > 0) ? text.getc(0) : "#";
      ok  = 1'b1;
      if (tag == "P") begin
        n  = $sscanf(text.substr(2, text.len() - 1), "%h", a);
        ok = (n == 1);
        if (ok) begin
          prog_words.push_back(a[31:0]);
        end
      end else if (tag == "E" && text.getc(2) == "S") begin
        // status line: halted, illegal, final pc
        n           = $sscanf(text.substr(4, text.len() - 1), "%h %h %h", a, b, c);
        ok          = (n == 3);
        exp_halted  = a;
        exp_illegal = b;
        exp_pc      = c;
      end else if (tag == "E") begin
        n  = $sscanf(text.substr(4, text.len() - 1), "%d %h", idx, a);
        ok = (n == 2);
        if (ok) begin
          exp_idx.push_back(idx);
          exp_val.push_back(a);
        end
      end else if (tag == "X") begin
        prog++;
        run_program(prog);
        prog_words.delete();
        exp_idx.delete();
        exp_val.delete();
      end
      if (!ok) begin
        file_errors++;
        $display("malformed line in the golden file: %s", text);
      end
    end
    $fclose(fd);
    if (prog == 0) begin
      file_errors++;
      $display("the golden file holds no program");
    end
  endtask

  initial begin
    start       = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    dbg_addr    = '0;
    tb_rst_n    = 1'b1;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    file_errors = 0;
    cycles_por  = 0;
    // power-on reset from the clock generator
    while (!por_n && cycles_por < 20) begin
      @(negedge clk);
      cycles_por++;
    end
    if (!por_n) begin
      timeouts++;
      $display("power-on reset was never released");
    end
    run_golden();
    $display("checks %0d, value errors %0d, timeouts %0d, file errors %0d, assertion fails %0d",
             checks, errors, timeouts, file_errors, dut_i.checker_i.assert_fails);
    if (errors == 0 && timeouts == 0 && file_errors == 0 &&
        dut_i.checker_i.assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/rv_core_golden.txt */
# P <instruction hex> | E S <halted> <illegal> <final pc hex> | E R <reg dec> <value hex>
# X runs the program collected so far, then the next one starts
P 00500093 addi x1, x0, 5
P ffd00113 addi x2, x0, -3
P 002081b3 add x3, x1, x2
P 40208233 sub x4, x1, x2
P 0020f2b3 and x5, x1, x2
P 0020e333 or x6, x1, x2
P 0020c3b3 xor x7, x1, x2
P 00112433 slt x8, x2, x1
P 0f017493 andi x9, x2, 0xf0
P 7000e513 ori x10, x1, 0x700
P fff14593 xori x11, x2, -1
P fff0a613 slti x12, x1, -1
P 123456b7 lui x13, 0x12345
P 00001717 auipc x14, 0x1
P 00c007ef jal x15, +12
P 00100813 addi x16, x0, 1 skipped
P 00100893 addi x17, x0, 1 skipped
P 02d03023 sd x13, 32(x0)
P 02003903 ld x18, 32(x0)
P 00100073 ebreak
E S 1 0 000000000000004c
E R 0 0000000000000000
E R 1 0000000000000005
E R 2 fffffffffffffffd
E R 3 0000000000000002
E R 4 0000000000000008
E R 5 0000000000000005
E R 6 fffffffffffffffd
E R 7 fffffffffffffff8
E R 8 0000000000000001
E R 9 00000000000000f0
E R 10 0000000000000705
E R 11 0000000000000002
E R 12 0000000000000000
E R 13 0000000012345000
E R 14 0000000000001034
E R 15 000000000000003c
E R 16 0000000000000000
E R 17 0000000000000000
E R 18 0000000012345000
X
P 00700293 addi x5, x0, 7
P 00900313 addi x6, x0, 9
P 006292b3 sll x5, x5, x6 unsupported
P 00100393 addi x7, x0, 1 not reached
E S 0 1 0000000000000008
E R 0 0000000000000000
E R 1 0000000000000000
E R 5 0000000000000007
E R 6 0000000000000009
E R 7 0000000000000000
X

/* flist.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_memory.sv
rtl/rv_fetch.sv
rtl/rv_core_top.sv
verification/tb_clock_gen.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv64 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f flist.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
